// ==== hdl/vsg_pkg.sv ====
package vsg_pkg;

    // geometry of one bank row
    localparam int NUM_SLICES = 4;
    localparam int SLICE_W    = 16;
    localparam int LINE_W     = NUM_SLICES * SLICE_W;

    // slice bank addressing
    localparam int ADDR_W     = 4;
    localparam int BANK_DEPTH = 16;

    // read tag echoed with the response
    localparam int TAG_W      = 4;

    // south skew line: column k sees the entry k*SKEW_STEP cycles late
    localparam int SKEW_DEPTH = 6;
    localparam int SKEW_STEP  = 2;

    // south write command
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } write_cmd_t;

    // south write data, one whole line
    typedef struct packed {
        logic [LINE_W-1:0] line;
    } write_data_t;

    // west read command
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0]  tag;
    } read_cmd_t;

    // reassembled line plus the command's tag
    typedef struct packed {
        logic [LINE_W-1:0] line;
        logic [TAG_W-1:0]  tag;
    } read_rsp_t;

endpackage

// ==== hdl/south_skew_line.sv ====
`timescale 1ns/10ps

module south_skew_line #(
    parameter type payload_t = vsg_pkg::write_cmd_t
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_vld,
    input  payload_t                        in_pld,
    output logic [vsg_pkg::NUM_SLICES-1:0]  tap_vld,
    output payload_t                        tap_pld [vsg_pkg::NUM_SLICES]
);
    import vsg_pkg::*;

    // stage s holds the input delayed by s+1 cycles
    logic [SKEW_DEPTH-1:0] vld_sr;
    payload_t              pld_sr [SKEW_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[SKEW_DEPTH-2:0], in_vld};
        end
    end

    // payload stages reset to zero too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SKEW_DEPTH; s++) begin
                pld_sr[s] <= '0;
            end
        end else begin
            pld_sr[0] <= in_pld;
            for (int s = 1; s < SKEW_DEPTH; s++) begin
                pld_sr[s] <= pld_sr[s-1];
            end
        end
    end

    // column taps
    for (genvar k = 0; k < NUM_SLICES; k++) begin : g_tap
        if (k == 0) begin : g_direct
            // column 0 sits right at the south edge with no delay
            assign tap_vld[k] = in_vld;
            assign tap_pld[k] = in_pld;
        end else begin : g_stage
            // delay of k*SKEW_STEP means stage index k*SKEW_STEP-1
            assign tap_vld[k] = vld_sr[k*SKEW_STEP-1];
            assign tap_pld[k] = pld_sr[k*SKEW_STEP-1];
        end
    end

endmodule

// ==== hdl/slice_bank.sv ====
`timescale 1ns/10ps

module slice_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_vld,
    input  vsg_pkg::write_cmd_t         cmd,
    input  logic                        data_vld,
    input  logic [vsg_pkg::SLICE_W-1:0] slice_data,
    input  logic                        rd_vld,
    input  logic [vsg_pkg::ADDR_W-1:0]  rd_addr,
    output logic [vsg_pkg::SLICE_W-1:0] rd_slice
);
    import vsg_pkg::*;

    logic [SLICE_W-1:0] mem [BANK_DEPTH];
    logic               wr_en;

    // command and data must arrive together, a lone tap is dropped
    assign wr_en = cmd_vld & data_vld;

    // memory comes out of reset as all zeros
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[cmd.addr] <= slice_data;
        end
    end

    // registered read, a same-cycle write to the same line
    // is not visible yet, so the old slice comes back
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            rd_slice <= mem[rd_addr];
        end
    end

endmodule

// ==== hdl/bank_group_row.sv ====
`timescale 1ns/10ps

module bank_group_row (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [vsg_pkg::NUM_SLICES-1:0]  cmd_tap_vld,
    input  vsg_pkg::write_cmd_t             cmd_tap [vsg_pkg::NUM_SLICES],
    input  logic [vsg_pkg::NUM_SLICES-1:0]  data_tap_vld,
    input  vsg_pkg::write_data_t            data_tap [vsg_pkg::NUM_SLICES],
    input  logic                            rd_cmd_vld,
    input  vsg_pkg::read_cmd_t              rd_cmd,
    output logic                            rd_rsp_vld,
    output vsg_pkg::read_rsp_t              rd_rsp
);
    import vsg_pkg::*;

    logic [SLICE_W-1:0] rd_slices [NUM_SLICES];
    logic [LINE_W-1:0]  rd_line;
    logic [TAG_W-1:0]   rd_tag_q;

    // one bank per column, each fed its own slice of the line
    for (genvar k = 0; k < NUM_SLICES; k++) begin : g_bank
        logic [SLICE_W-1:0] wr_slice;

        assign wr_slice = data_tap[k].line[k*SLICE_W +: SLICE_W];

        slice_bank u_slice_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .cmd_vld    (cmd_tap_vld[k]),
            .cmd        (cmd_tap[k]),
            .data_vld   (data_tap_vld[k]),
            .slice_data (wr_slice),
            .rd_vld     (rd_cmd_vld),
            .rd_addr    (rd_cmd.addr),
            .rd_slice   (rd_slices[k])
        );
    end

    // response strobe lines up with the bank read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_rsp_vld <= 1'b0;
        end else begin
            rd_rsp_vld <= rd_cmd_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cmd_vld) begin
            rd_tag_q <= rd_cmd.tag;
        end
    end

    // slice k goes back to bits k*SLICE_W and up
    always_comb begin
        rd_line = '0;
        for (int k = 0; k < NUM_SLICES; k++) begin
            rd_line[k*SLICE_W +: SLICE_W] = rd_slices[k];
        end
    end

    assign rd_rsp.line = rd_line;
    assign rd_rsp.tag  = rd_tag_q;

endmodule

// ==== hdl/vec_sram_group.sv ====
`timescale 1ns/10ps

module vec_sram_group (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_cmd_vld,
    input  vsg_pkg::write_cmd_t     wr_cmd,
    input  logic                    wr_data_vld,
    input  vsg_pkg::write_data_t    wr_data,
    input  logic                    rd_cmd_vld,
    input  vsg_pkg::read_cmd_t      rd_cmd,
    output logic                    rd_rsp_vld,
    output vsg_pkg::read_rsp_t      rd_rsp
);
    import vsg_pkg::*;

    // per-column taps of the south skew lines
    logic [NUM_SLICES-1:0] cmd_tap_vld;
    write_cmd_t            cmd_tap [NUM_SLICES];
    logic [NUM_SLICES-1:0] data_tap_vld;
    write_data_t           data_tap [NUM_SLICES];

    // write command skew
    south_skew_line #(
        .payload_t (write_cmd_t)
    ) u_cmd_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vld  (wr_cmd_vld),
        .in_pld  (wr_cmd),
        .tap_vld (cmd_tap_vld),
        .tap_pld (cmd_tap)
    );

    // write data skew, same taps as the command
    south_skew_line #(
        .payload_t (write_data_t)
    ) u_data_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vld  (wr_data_vld),
        .in_pld  (wr_data),
        .tap_vld (data_tap_vld),
        .tap_pld (data_tap)
    );

    // row of slice banks, west read enters here
    bank_group_row u_bank_row (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_tap_vld  (cmd_tap_vld),
        .cmd_tap      (cmd_tap),
        .data_tap_vld (data_tap_vld),
        .data_tap     (data_tap),
        .rd_cmd_vld   (rd_cmd_vld),
        .rd_cmd       (rd_cmd),
        .rd_rsp_vld   (rd_rsp_vld),
        .rd_rsp       (rd_rsp)
    );

endmodule

// ==== bench/vec_sram_group_assertions.sv ====
`timescale 1ns/10ps

module vec_sram_group_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               rd_cmd_vld,
    input vsg_pkg::read_cmd_t rd_cmd,
    input logic               rd_rsp_vld,
    input vsg_pkg::read_rsp_t rd_rsp
);

    int fail_count = 0;

    // every read strobe is answered on the next edge
    a_rsp_after_cmd: assert property (
        @(posedge clk) disable iff (!rst_n) rd_cmd_vld |=> rd_rsp_vld
    ) else begin
        $error("read response missing one cycle after a read command");
        fail_count++;
    end

    // and no response without a command
    a_rsp_needs_cmd: assert property (
        @(posedge clk) disable iff (!rst_n) rd_rsp_vld |-> $past(rd_cmd_vld)
    ) else begin
        $error("read response without a read command one cycle earlier");
        fail_count++;
    end

    a_tag_echo: assert property (
        @(posedge clk) disable iff (!rst_n) rd_rsp_vld |-> rd_rsp.tag == $past(rd_cmd.tag)
    ) else begin
        $error("response tag differs from the tag of the read command");
        fail_count++;
    end

    a_vld_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(rd_rsp_vld)
    ) else begin
        $error("rd_rsp_vld is unknown after reset");
        fail_count++;
    end

endmodule

bind vec_sram_group vec_sram_group_assertions u_vsg_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_cmd_vld (rd_cmd_vld),
    .rd_cmd     (rd_cmd),
    .rd_rsp_vld (rd_rsp_vld),
    .rd_rsp     (rd_rsp)
);

// ==== bench/tb_vec_sram_group.sv ====
`timescale 1ns/10ps

module tb_vec_sram_group;
    import vsg_pkg::*;

    localparam int NUM_TESTS  = 19;
    localparam int CLK_HALF   = 5;
    localparam int DRIVE_DLY  = 1;
    // last column lands 6 cycles after entry and is readable one cycle later
    localparam int RD_SETTLE  = 7;
    localparam int MAX_CYCLES = 4 * NUM_TESTS * 10 + 50;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_WRITE_READ
    } op_t;

    typedef struct {
        string             name;
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] exp_line;
    } test_entry_t;

    // read in flight that waits for its response
    typedef struct {
        string             name;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] exp_line;
        int                issue_cycle;
    } pending_rd_t;

    logic        clk;
    logic        rst_n;
    logic        wr_cmd_vld;
    write_cmd_t  wr_cmd;
    logic        wr_data_vld;
    write_data_t wr_data;
    logic        rd_cmd_vld;
    read_cmd_t   rd_cmd;
    logic        rd_rsp_vld;
    read_rsp_t   rd_rsp;

    test_entry_t       tests [NUM_TESTS];
    pending_rd_t       pending [$];
    logic [LINE_W-1:0] ref_mem [BANK_DEPTH];
    int                last_wr_cycle [BANK_DEPTH];
    int                num_entries;
    int                cycle;
    int                errors;
    int                checks;
    int                tests_done;
    integer            seed;

    vec_sram_group dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_cmd_vld  (wr_cmd_vld),
        .wr_cmd      (wr_cmd),
        .wr_data_vld (wr_data_vld),
        .wr_data     (wr_data),
        .rd_cmd_vld  (rd_cmd_vld),
        .rd_cmd      (rd_cmd),
        .rd_rsp_vld  (rd_rsp_vld),
        .rd_rsp      (rd_rsp)
    );

    initial begin
        clk = 1'b0;
    end

    always #CLK_HALF clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] l;
        l = {$random(seed), $random(seed)};
        return l;
    endfunction

    // appends one entry and works out its expected line from the reference memory
    task automatic add_entry(input string name, input op_t op,
                             input logic [ADDR_W-1:0] addr, input logic [TAG_W-1:0] tag);
        test_entry_t e;
        e.name = name;
        e.op   = op;
        e.addr = addr;
        e.tag  = tag;
        if (op == OP_READ) begin
            e.line = '0;
        end else begin
            e.line = random_line();
        end
        // a read sees all earlier writes but not one in its own cycle
        e.exp_line = ref_mem[addr];
        if (op != OP_READ) begin
            ref_mem[addr] = e.line;
        end
        tests[num_entries] = e;
        num_entries++;
    endtask

    task automatic build_table();
        add_entry("reset_read_a3",  OP_READ,       4'd3,  4'd1);
        add_entry("reset_read_a15", OP_READ,       4'd15, 4'd2);
        add_entry("write_a5",       OP_WRITE,      4'd5,  4'd0);
        add_entry("read_a5",        OP_READ,       4'd5,  4'd3);
        // several writes in flight in the skew lines at once
        add_entry("burst_wr_a0",    OP_WRITE,      4'd0,  4'd0);
        add_entry("burst_wr_a1",    OP_WRITE,      4'd1,  4'd0);
        add_entry("burst_wr_a2",    OP_WRITE,      4'd2,  4'd0);
        add_entry("burst_wr_a3",    OP_WRITE,      4'd3,  4'd0);
        add_entry("burst_rd_a0",    OP_READ,       4'd0,  4'd4);
        add_entry("burst_rd_a1",    OP_READ,       4'd1,  4'd5);
        add_entry("burst_rd_a2",    OP_READ,       4'd2,  4'd6);
        add_entry("burst_rd_a3",    OP_READ,       4'd3,  4'd7);
        add_entry("overwrite_a5",   OP_WRITE,      4'd5,  4'd0);
        add_entry("reread_a5",      OP_READ,       4'd5,  4'd8);
        // same-cycle read returns the line from before the write
        add_entry("wr_rd_same_a1",  OP_WRITE_READ, 4'd1,  4'd9);
        add_entry("read_new_a1",    OP_READ,       4'd1,  4'd10);
        add_entry("b2b_rd_a5",      OP_READ,       4'd5,  4'd11);
        add_entry("b2b_rd_a0",      OP_READ,       4'd0,  4'd12);
        add_entry("b2b_rd_a15",     OP_READ,       4'd15, 4'd13);
    endtask

    task automatic next_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_inputs();
        wr_cmd_vld  = 1'b0;
        wr_cmd      = '0;
        wr_data_vld = 1'b0;
        wr_data     = '0;
        rd_cmd_vld  = 1'b0;
        rd_cmd      = '0;
    endtask

    task automatic apply_entry(input int idx);
        test_entry_t e;
        pending_rd_t p;
        e = tests[idx];
        if (e.op != OP_WRITE) begin
            // hold the read until every slice of the last write has landed
            while (cycle < last_wr_cycle[e.addr] + RD_SETTLE) begin
                next_slot();
            end
        end
        if (e.op != OP_READ) begin
            wr_cmd_vld   = 1'b1;
            wr_cmd.addr  = e.addr;
            wr_data_vld  = 1'b1;
            wr_data.line = e.line;
            last_wr_cycle[e.addr] = cycle;
        end
        if (e.op != OP_WRITE) begin
            rd_cmd_vld  = 1'b1;
            rd_cmd.addr = e.addr;
            rd_cmd.tag  = e.tag;
            p.name        = e.name;
            p.tag         = e.tag;
            p.exp_line    = e.exp_line;
            p.issue_cycle = cycle;
            pending.push_back(p);
        end
        next_slot();
        idle_inputs();
        if (e.op == OP_WRITE) begin
            $display("[ok]   %s: write issued at cycle %0d", e.name, cycle - 1);
            tests_done++;
        end
    endtask

    // read responses checked on the falling edge
    always @(negedge clk) begin : rsp_check
        pending_rd_t p;
        int          errs_before;
        if (rst_n === 1'b1) begin
            if (rd_rsp_vld) begin
                assert (pending.size() > 0) else begin
                    $display("Unexpected read response with no read command outstanding");
                    errors++;
                end
                if (pending.size() > 0) begin
                    p = pending.pop_front();
                    errs_before = errors;
                    checks += 3;
                    assert (cycle == p.issue_cycle + 1) else begin
                        $display("** Error [%s]: latency expected 1, actual %0d",
                                 p.name, cycle - p.issue_cycle);
                        errors++;
                    end
                    assert (rd_rsp.tag === p.tag) else begin
                        $display("** Error [%s]: tag expected %h, actual %h",
                                 p.name, p.tag, rd_rsp.tag);
                        errors++;
                    end
                    assert (rd_rsp.line === p.exp_line) else begin
                        $display("** Error [%s]: line expected %h, actual %h",
                                 p.name, p.exp_line, rd_rsp.line);
                        errors++;
                    end
                    if (errors == errs_before) begin
                        $display("[ok]   %s: tag %h line %h", p.name, rd_rsp.tag, rd_rsp.line);
                    end else begin
                        $display("[FAIL] %s", p.name);
                    end
                    tests_done++;
                end
            end else if (pending.size() > 0) begin
                assert (cycle <= pending[0].issue_cycle) else begin
                    p = pending.pop_front();
                    $display("Read response for %s did not arrive one cycle after its command",
                             p.name);
                    $display("[FAIL] %s", p.name);
                    errors++;
                    tests_done++;
                end
            end
        end
    end

    initial begin : stimulus
        int asrt_fails;
        seed        = 32'h4e77a0c0;
        errors      = 0;
        checks      = 0;
        tests_done  = 0;
        num_entries = 0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            ref_mem[i]       = '0;
            last_wr_cycle[i] = -RD_SETTLE;
        end
        rst_n = 1'b0;
        idle_inputs();
        build_table();

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        next_slot();

        for (int i = 0; i < num_entries; i++) begin
            apply_entry(i);
        end
        // let the last responses come back
        while (pending.size() > 0) begin
            next_slot();
        end
        next_slot();

        assert (tests_done == num_entries) else begin
            $display("Only %0d of %0d tests completed", tests_done, num_entries);
            errors++;
        end
        asrt_fails = dut.u_vsg_assertions.fail_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_done, checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (rst_n === 1'b1);
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("Run stopped after %0d cycles without reaching the end of the table",
                 MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== files.f ====
hdl/vsg_pkg.sv
hdl/south_skew_line.sv
hdl/slice_bank.sv
hdl/bank_group_row.sv
hdl/vec_sram_group.sv
bench/vec_sram_group_assertions.sv
bench/tb_vec_sram_group.sv

// ==== Bender.yml ====
package:
  name: vec_sram_group

sources:
  # design, package first
  - files:
      - hdl/vsg_pkg.sv
      - hdl/south_skew_line.sv
      - hdl/slice_bank.sv
      - hdl/bank_group_row.sv
      - hdl/vec_sram_group.sv

  # verification only
  - target: test
    files:
      - bench/vec_sram_group_assertions.sv
      - bench/tb_vec_sram_group.sv
